/* Makefile */
TOOL  = verilator
FLAGS = --binary --timing --assert --timescale 1ns/100ps
TOP   = spiUnitTb
FLIST = flist.f
LOG   = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Simulation passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* flist.f */
+incdir+hdl
hdl/spiUnitPkg.sv
hdl/spiFrameDecode.sv
hdl/usiBusExecute.sv
hdl/misoResult.sv
hdl/spiUnit.sv
tb/spiUnitTb.sv

/* hdl/misoResult.sv */
// MISO driver, holds the bus read result and shifts it to the SPI master after the dummy byte
`default_nettype none
`include "spiUnit_consts.svh"

module misoResult (
	input  logic                      sysClk,
	input  logic                      rstN,
	input  logic [`SPI_DATA_BITS-1:0] rdData,
	input  logic                      rdValid,
	input  logic                      shiftStart,
	input  logic                      sckFall,
	input  logic                      spiCsN,
	output logic                      spiMiso
);

	logic [`SPI_SYNC_STAGES-1:0] csSr;
	logic                        csSync;
	logic [`SPI_DATA_BITS-1:0]   rdWord;
	logic [`SPI_DATA_BITS-1:0]   shiftReg;
	logic                        pending;
	logic                        active;
	logic                        holdFirst;

	assign csSync = csSr[`SPI_SYNC_STAGES-1];

	// ------------------------------
	// Pending word and shift control
	// ------------------------------
	always_ff @(posedge sysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			csSr      <= '1;
			pending   <= 1'b0;
			active    <= 1'b0;
			holdFirst <= 1'b0;
		end
		else
		begin
			csSr <= {csSr[`SPI_SYNC_STAGES-2:0], spiCsN};
			if (shiftStart)
				pending <= 1'b0;
			else if (rdValid)
				pending <= 1'b1;
			// Frame end stops driving
			if (csSync)
			begin
				active    <= 1'b0;
				holdFirst <= 1'b0;
			end
			else if (shiftStart)
			begin
				active    <= 1'b1;
				holdFirst <= 1'b1;
			end
			// Bit 31 must survive the fall before its sampling edge
			else if (sckFall)
				holdFirst <= 1'b0;
		end
	end

	always_ff @(posedge sysClk)
	begin
		if (rdValid)
			rdWord <= rdData;
		// Late rdValid on the same cycle still makes it
		if (shiftStart)
			shiftReg <= rdValid ? rdData : rdWord;
		else if (sckFall && active && !holdFirst)
			shiftReg <= {shiftReg[`SPI_DATA_BITS-2:0], 1'b1};
	end

	// Idle high
	assign spiMiso = (spiCsN || !active) ? 1'b1 : shiftReg[`SPI_DATA_BITS-1];

	// Bus read has to finish within the dummy byte
	readInTime: assert property (@(posedge sysClk) disable iff (!rstN)
		shiftStart |-> (pending || rdValid))
		else $error("Read data not ready at end of dummy byte");

endmodule

`default_nettype wire

/* hdl/spiFrameDecode.sv */
// SPI mode 0 slave front end, synchronizes the pins and assembles frames into USI commands
`default_nettype none
`include "spiUnit_consts.svh"

module spiFrameDecode
	import spiUnitPkg::*;
(
	input  logic    sysClk,
	input  logic    rstN,
	input  logic    spiSck,
	input  logic    spiCsN,
	input  logic    spiMosi,
	output usiCmd_t cmd,
	output logic    frameIntr,
	output logic    shiftStart,
	output logic    sckFall
);

	localparam int CNT_BITS = $clog2(`SPI_DATA_BITS);

	// ------------------------------
	// Pin synchronizers
	// ------------------------------
	logic [`SPI_SYNC_STAGES-1:0] sckSr;
	logic [`SPI_SYNC_STAGES-1:0] csSr;
	logic [`SPI_SYNC_STAGES-1:0] mosiSr;
	logic                        sckDly;
	logic                        sckSync;
	logic                        csSync;
	logic                        mosiSync;
	logic                        sckRise;

	always_ff @(posedge sysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			sckSr  <= '0;
			csSr   <= '1;
			mosiSr <= '0;
			sckDly <= 1'b0;
		end
		else
		begin
			sckSr  <= {sckSr[`SPI_SYNC_STAGES-2:0], spiSck};
			csSr   <= {csSr[`SPI_SYNC_STAGES-2:0], spiCsN};
			mosiSr <= {mosiSr[`SPI_SYNC_STAGES-2:0], spiMosi};
			// Previous SCK level for edge detect
			sckDly <= sckSync;
		end
	end

	assign sckSync  = sckSr[`SPI_SYNC_STAGES-1];
	assign csSync   = csSr[`SPI_SYNC_STAGES-1];
	assign mosiSync = mosiSr[`SPI_SYNC_STAGES-1];
	assign sckRise  = sckSync & ~sckDly;
	assign sckFall  = ~sckSync & sckDly;

	// ------------------------------
	// Field shifter and bit count
	// ------------------------------
	decodeState_e                state;
	logic [CNT_BITS-1:0]         bitCnt;
	logic [CNT_BITS-1:0]         fieldLast;
	logic                        lastBit;
	logic [`SPI_DATA_BITS-1:0]   shiftIn;
	logic [`SPI_DATA_BITS-1:0]   newWord;
	logic                        opValid;

	// Index of the final bit in the current field
	always_comb
	begin
		case (state)
			DEC_OPCODE: fieldLast = CNT_BITS'(`SPI_OP_BITS - 1);
			DEC_ADRS:   fieldLast = CNT_BITS'(`SPI_ADRS_BITS - 1);
			DEC_DUMMY:  fieldLast = CNT_BITS'(7);
			default:    fieldLast = CNT_BITS'(`SPI_DATA_BITS - 1);
		endcase
	end

	// Word as it stands once the sampled bit is in
	assign newWord = {shiftIn[`SPI_DATA_BITS-2:0], mosiSync};
	assign lastBit = sckRise && (bitCnt == fieldLast);
	assign opValid = (newWord[`SPI_OP_BITS-1:0] == OP_WRITE) ||
	                 (newWord[`SPI_OP_BITS-1:0] == OP_READ);

	// ------------------------------
	// Frame FSM
	// ------------------------------
	logic                      cmdValid;
	spiOpcode_e                opReg;
	logic [`SPI_ADRS_BITS-1:0] adrsReg;
	logic [`SPI_DATA_BITS-1:0] wdReg;

	always_ff @(posedge sysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			state      <= DEC_IDLE;
			bitCnt     <= '0;
			cmdValid   <= 1'b0;
			shiftStart <= 1'b0;
			frameIntr  <= 1'b0;
		end
		else
		begin
			cmdValid   <= 1'b0;
			shiftStart <= 1'b0;
			// Only valid opcodes ever reach cmdValid
			frameIntr  <= cmdValid;
			if (state == DEC_IDLE)
				bitCnt <= '0;
			else if (sckRise)
				bitCnt <= lastBit ? '0 : bitCnt + 1'b1;
			// CS high aborts whatever is in flight
			if (csSync)
				state <= DEC_IDLE;
			else if (lastBit)
			begin
				case (state)
					DEC_OPCODE:
						state <= opValid ? DEC_ADRS : DEC_DROP;
					DEC_ADRS:
					begin
						// Read goes to the bus now, the dummy byte covers its latency
						if (opReg == OP_READ)
						begin
							cmdValid <= 1'b1;
							state    <= DEC_DUMMY;
						end
						else
							state <= DEC_DATA;
					end
					DEC_DUMMY:
					begin
						shiftStart <= 1'b1;
						state      <= DEC_DROP;
					end
					DEC_DATA:
					begin
						cmdValid <= 1'b1;
						state    <= DEC_DROP;
					end
					default:
						state <= state;
				endcase
			end
			else if (state == DEC_IDLE)
				state <= DEC_OPCODE;
		end
	end

	// Captured fields
	always_ff @(posedge sysClk)
	begin
		if (sckRise)
			shiftIn <= newWord;
		if (lastBit && state == DEC_OPCODE)
			opReg <= spiOpcode_e'(newWord[`SPI_OP_BITS-1:0]);
		if (lastBit && state == DEC_ADRS)
			adrsReg <= newWord[`SPI_ADRS_BITS-1:0];
		if (lastBit && state == DEC_DATA)
			wdReg <= newWord;
	end

	always_comb
	begin
		cmd.valid = cmdValid;
		cmd.op    = opReg;
		cmd.adrs  = adrsReg;
		cmd.wd    = wdReg;
	end

	// A command must never escape after the master has released CS
	cmdInsideFrame: assert property (@(posedge sysClk) disable iff (!rstN)
		cmd.valid |-> !csSync)
		else $error("cmd.valid raised while CS is high");

endmodule

`default_nettype wire

/* hdl/spiUnit.sv */
// SPI slave unit top, bridges an external SPI master onto the USI register bus
`default_nettype none
`include "spiUnit_consts.svh"

module spiUnit
	import spiUnitPkg::*;
(
	input  logic                      sysClk,
	input  logic                      rstN,
	// SPI pins
	input  logic                      spiSck,
	input  logic                      spiCsN,
	input  logic                      spiMosi,
	output logic                      spiMiso,
	// USI bus
	output logic                      usiReq,
	output usiReq_t                   usiInfo,
	input  logic                      usiAck,
	input  logic [`SPI_DATA_BITS-1:0] usiRd,
	// One pulse per accepted frame
	output logic                      frameIntr
);

	usiCmd_t                   cmd;
	logic [`SPI_DATA_BITS-1:0] rdData;
	logic                      rdValid;
	logic                      shiftStart;
	logic                      sckFall;

	// ------------------------------
	// Frame in, bus out, result back
	// ------------------------------
	spiFrameDecode u_decode (
		.sysClk     (sysClk),
		.rstN       (rstN),
		.spiSck     (spiSck),
		.spiCsN     (spiCsN),
		.spiMosi    (spiMosi),
		.cmd        (cmd),
		.frameIntr  (frameIntr),
		.shiftStart (shiftStart),
		.sckFall    (sckFall)
	);

	usiBusExecute u_execute (
		.sysClk  (sysClk),
		.rstN    (rstN),
		.cmd     (cmd),
		.usiReq  (usiReq),
		.usiInfo (usiInfo),
		.usiAck  (usiAck),
		.usiRd   (usiRd),
		.rdData  (rdData),
		.rdValid (rdValid)
	);

	misoResult u_result (
		.sysClk     (sysClk),
		.rstN       (rstN),
		.rdData     (rdData),
		.rdValid    (rdValid),
		.shiftStart (shiftStart),
		.sckFall    (sckFall),
		.spiCsN     (spiCsN),
		.spiMiso    (spiMiso)
	);

endmodule

`default_nettype wire

/* hdl/spiUnitPkg.sv */
// Opcode, state and transfer types shared by the SPI slave unit, imported by each module
`default_nettype none
`include "spiUnit_consts.svh"

package spiUnitPkg;

	// ------------------------------
	// Frame opcodes
	// ------------------------------
	// Any other value is dropped by the decoder
	typedef enum logic [`SPI_OP_BITS-1:0] {
		OP_WRITE = 8'h02,
		OP_READ  = 8'h03
	} spiOpcode_e;

	// ------------------------------
	// FSM states
	// ------------------------------
	// Frame decoder, DROP waits for CS high
	typedef enum logic [2:0] {
		DEC_IDLE,
		DEC_OPCODE,
		DEC_ADRS,
		DEC_DUMMY,
		DEC_DATA,
		DEC_DROP
	} decodeState_e;

	// Four-phase bus handshake
	typedef enum logic [1:0] {
		BUS_IDLE,
		BUS_REQ,
		BUS_RELEASE,
		BUS_DONE
	} busState_e;

	// ------------------------------
	// Transfers
	// ------------------------------
	// Decoded frame, valid is a single cycle pulse
	typedef struct packed {
		logic                      valid;
		spiOpcode_e                op;
		logic [`SPI_ADRS_BITS-1:0] adrs;
		logic [`SPI_DATA_BITS-1:0] wd;
	} usiCmd_t;

	// Held on the USI bus for one request
	typedef struct packed {
		logic [`SPI_ADRS_BITS-1:0] adrs;
		logic [`SPI_DATA_BITS-1:0] wd;
		logic                      we;
	} usiReq_t;

endpackage

`default_nettype wire

/* hdl/spiUnit_consts.svh */
// Bus and frame widths for the SPI slave unit, included by its package and RTL modules
`ifndef SPI_UNIT_CONSTS_SVH
`define SPI_UNIT_CONSTS_SVH

// ------------------------------
// USI register bus
// ------------------------------

// Register address width
`define SPI_ADRS_BITS 16

// Read and write data width
`define SPI_DATA_BITS 32

// ------------------------------
// SPI frame
// ------------------------------

// Opcode field, first byte of every frame
`define SPI_OP_BITS 8

// Flops per pin synchronizer
`define SPI_SYNC_STAGES 2

`endif

/* hdl/usiBusExecute.sv */
// USI bus master side, runs each decoded SPI command as one four-phase req/ack transfer
`default_nettype none
`include "spiUnit_consts.svh"

module usiBusExecute
	import spiUnitPkg::*;
(
	input  logic                      sysClk,
	input  logic                      rstN,
	input  usiCmd_t                   cmd,
	output logic                      usiReq,
	output usiReq_t                   usiInfo,
	input  logic                      usiAck,
	input  logic [`SPI_DATA_BITS-1:0] usiRd,
	output logic [`SPI_DATA_BITS-1:0] rdData,
	output logic                      rdValid
);

	busState_e busState;
	logic      isRead;

	// ------------------------------
	// Handshake FSM
	// ------------------------------
	always_ff @(posedge sysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			busState <= BUS_IDLE;
			isRead   <= 1'b0;
		end
		else
		begin
			case (busState)
				BUS_IDLE:
					if (cmd.valid)
					begin
						isRead   <= (cmd.op == OP_READ);
						busState <= BUS_REQ;
					end
				// Wait for slave ack
				BUS_REQ:
					if (usiAck)
						busState <= BUS_RELEASE;
				// Req is low here, wait for ack to fall
				BUS_RELEASE:
					if (!usiAck)
						busState <= BUS_DONE;
				default:
					busState <= BUS_IDLE;
			endcase
		end
	end

	// Request info and read capture
	always_ff @(posedge sysClk)
	begin
		if (busState == BUS_IDLE && cmd.valid)
		begin
			usiInfo.adrs <= cmd.adrs;
			usiInfo.wd   <= cmd.wd;
			usiInfo.we   <= (cmd.op == OP_WRITE);
		end
		// Slave data is valid alongside ack
		if (busState == BUS_REQ && usiAck && isRead)
			rdData <= usiRd;
	end

	assign usiReq  = (busState == BUS_REQ);
	assign rdValid = (busState == BUS_DONE) && isRead;

	// ------------------------------
	// Protocol checks
	// ------------------------------
	// Frames must not outrun the bus
	noOverlap: assert property (@(posedge sysClk) disable iff (!rstN)
		cmd.valid |-> busState == BUS_IDLE)
		else $error("New command while bus transfer is busy");

endmodule

`default_nettype wire

/* tb/spiUnitTb.sv */
// Self-checking testbench for the SPI slave unit, drives SPI frames and models the USI register bus
`default_nettype none
`include "spiUnit_consts.svh"

module spiUnitTb
	import spiUnitPkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int NUM_RANDOM = 60;
	localparam int NUM_FRAMES = 8 + NUM_RANDOM;
	// Half an SCK period in sysClk cycles, 40 ns SCK
	localparam int HALF_SCK   = 5;
	localparam int CS_GAP     = 6;

	logic                      sysClk;
	logic                      rstN;
	logic                      spiSck;
	logic                      spiCsN;
	logic                      spiMosi;
	logic                      spiMiso;
	logic                      usiReq;
	usiReq_t                   usiInfo;
	logic                      usiAck;
	logic [`SPI_DATA_BITS-1:0] usiRd;
	logic                      frameIntr;

	integer                    seed = 32'h42442ef3;
	int                        errCount;
	int                        reqCount;
	int                        intrCount;
	int                        expReqs;
	int                        expIntrs;
	int                        frameCount;
	usiReq_t                   expReqQ[$];
	// Bus slave contents and the expected view of them
	logic [`SPI_DATA_BITS-1:0] regMem[256];
	logic [`SPI_DATA_BITS-1:0] refMem[256];

	always #2 sysClk = ~sysClk;

	spiUnit u_dut (
		.sysClk    (sysClk),
		.rstN      (rstN),
		.spiSck    (spiSck),
		.spiCsN    (spiCsN),
		.spiMosi   (spiMosi),
		.spiMiso   (spiMiso),
		.usiReq    (usiReq),
		.usiInfo   (usiInfo),
		.usiAck    (usiAck),
		.usiRd     (usiRd),
		.frameIntr (frameIntr)
	);

	// ------------------------------
	// Reference model
	// ------------------------------
	// Reset pattern, every index bit shows up
	function automatic logic [`SPI_DATA_BITS-1:0] fillWord(input logic [7:0] idx);
		return {idx ^ 8'hC3, idx, ~idx, idx + 8'h5A};
	endfunction

	function automatic logic [`SPI_DATA_BITS-1:0] refRead(
		input logic [`SPI_ADRS_BITS-1:0] adrs);
		return refMem[adrs[7:0]];
	endfunction

	// ------------------------------
	// Compare tasks
	// ------------------------------
	task automatic checkUsiReq(input usiReq_t got, input usiReq_t exp);
		// Write data only means something for writes
		if (got.adrs !== exp.adrs || got.we !== exp.we || (exp.we && got.wd !== exp.wd))
		begin
			errCount++;
			$display("ERROR @%0t ns: usiInfo adrs %h wd %h we %b, expected adrs %h wd %h we %b",
				$time, got.adrs, got.wd, got.we, exp.adrs, exp.wd, exp.we);
		end
	endtask

	task automatic checkRdWord(input logic [`SPI_DATA_BITS-1:0] got,
		input logic [`SPI_DATA_BITS-1:0] exp);
		if (got !== exp)
		begin
			errCount++;
			$display("ERROR @%0t ns: MISO word %h, expected %h", $time, got, exp);
		end
	endtask

	task automatic checkCount(input string what, input int got, input int exp);
		if (got != exp)
		begin
			errCount++;
			$display("ERROR @%0t ns: %s count %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic checkLevel(input string what, input logic got, input logic exp);
		if (got !== exp)
		begin
			errCount++;
			$display("ERROR @%0t ns: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	// ------------------------------
	// SPI master driver
	// ------------------------------
	// Lands 1 ns after a rising sysClk edge
	task automatic waitCycles(input int n);
		repeat (n) @(posedge sysClk);
		#1;
	endtask

	// Mode 0, MSB first, MISO sampled just before each rising SCK
	task automatic shiftFrame(input logic [63:0] frame, input int nBits,
		output logic [`SPI_DATA_BITS-1:0] misoWord);
		int i;
		misoWord = '0;
		frameCount++;
		spiCsN = 1'b0;
		waitCycles(HALF_SCK);
		for (i = 0; i < nBits; i++)
		begin
			spiMosi = frame[63-i];
			waitCycles(HALF_SCK);
			// Read data follows opcode, address and dummy byte
			if (i >= 32)
				misoWord = {misoWord[`SPI_DATA_BITS-2:0], spiMiso};
			spiSck = 1'b1;
			waitCycles(HALF_SCK);
			spiSck = 1'b0;
		end
		waitCycles(HALF_SCK);
		spiCsN  = 1'b1;
		spiMosi = 1'b0;
		waitCycles(CS_GAP);
		// Let any bus transfer drain
		while (usiReq || usiAck)
			waitCycles(1);
		checkCount("bus request", reqCount, expReqs);
		checkCount("frame interrupt", intrCount, expIntrs);
	endtask

	task automatic writeFrame(input logic [`SPI_ADRS_BITS-1:0] adrs,
		input logic [`SPI_DATA_BITS-1:0] wd);
		logic [`SPI_DATA_BITS-1:0] misoWord;
		expReqQ.push_back('{adrs: adrs, wd: wd, we: 1'b1});
		expReqs++;
		expIntrs++;
		refMem[adrs[7:0]] = wd;
		shiftFrame({OP_WRITE, adrs, wd, 8'h00}, 56, misoWord);
	endtask

	task automatic readFrame(input logic [`SPI_ADRS_BITS-1:0] adrs);
		logic [`SPI_DATA_BITS-1:0] misoWord;
		logic [`SPI_DATA_BITS-1:0] expWord;
		expWord = refRead(adrs);
		expReqQ.push_back('{adrs: adrs, wd: '0, we: 1'b0});
		expReqs++;
		expIntrs++;
		shiftFrame({OP_READ, adrs, 40'h0}, 64, misoWord);
		checkRdWord(misoWord, expWord);
	endtask

	// ------------------------------
	// USI register model
	// ------------------------------
	initial
	begin
		int ackDelay;
		usiReq_t info;
		usiAck = 1'b0;
		usiRd  = '0;
		forever
		begin
			waitCycles(1);
			if (usiReq && !usiAck)
			begin
				ackDelay = 1 + int'($unsigned($random(seed)) % 6);
				repeat (ackDelay - 1)
					waitCycles(1);
				info = usiInfo;
				if (info.we)
					regMem[info.adrs[7:0]] = info.wd;
				else
					usiRd = regMem[info.adrs[7:0]];
				usiAck = 1'b1;
				// Hold ack until req falls
				waitCycles(1);
				while (usiReq)
					waitCycles(1);
				usiAck = 1'b0;
			end
		end
	end

	// Request monitor, usiInfo is settled 1 ns after req rises
	always @(posedge usiReq)
	begin
		#1;
		reqCount++;
		if (expReqQ.size() == 0)
		begin
			errCount++;
			$display("Bus request to address %h at %0t ns without a frame that asks for it",
				usiInfo.adrs, $time);
		end
		else
			checkUsiReq(usiInfo, expReqQ.pop_front());
	end

	always @(negedge sysClk)
	begin
		if (frameIntr)
			intrCount++;
	end

	// ------------------------------
	// Stimulus
	// ------------------------------
	initial
	begin
		int i;
		logic [`SPI_ADRS_BITS-1:0] adrs;
		logic [`SPI_DATA_BITS-1:0] wd;
		logic [`SPI_DATA_BITS-1:0] misoWord;
		sysClk  = 1'b0;
		rstN    = 1'b0;
		spiSck  = 1'b0;
		spiCsN  = 1'b1;
		spiMosi = 1'b0;
		for (i = 0; i < 256; i++)
		begin
			regMem[i] = fillWord(8'(i));
			refMem[i] = fillWord(8'(i));
		end
		waitCycles(4);
		rstN = 1'b1;
		waitCycles(2);
		// Quiet outputs before any frame
		checkLevel("usiReq", usiReq, 1'b0);
		checkLevel("frameIntr", frameIntr, 1'b0);
		checkLevel("spiMiso", spiMiso, 1'b1);
		// Write, read back, read an untouched register
		writeFrame(16'hA534, 32'hDEADBEEF);
		readFrame(16'hA534);
		readFrame(16'h12F0);
		// Bad opcode is dropped, next frame still works
		shiftFrame({8'h5A, 16'h0356, 32'h0BADF00D, 8'h00}, 56, misoWord);
		writeFrame(16'h0356, 32'h13579BDF);
		// CS released mid address then mid data
		shiftFrame({OP_WRITE, 16'h0356, 32'hFFFFFFFF, 8'h00}, 16, misoWord);
		shiftFrame({OP_WRITE, 16'h0356, 32'hFFFFFFFF, 8'h00}, 40, misoWord);
		readFrame(16'h0356);
		// Random mix over 16 registers, high address byte varies
		for (i = 0; i < NUM_RANDOM; i++)
		begin
			adrs = {8'($random(seed)), 4'h0, 4'($random(seed))};
			wd   = $random(seed);
			if ($random(seed) & 1)
				writeFrame(adrs, wd);
			else
				readFrame(adrs);
		end
		if (expReqQ.size() != 0)
		begin
			errCount++;
			$display("%0d expected bus requests never appeared", expReqQ.size());
		end
		$display("Frames %0d, bus requests %0d, interrupts %0d, errors %0d",
			frameCount, reqCount, intrCount, errCount);
		if (errCount == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

	// Watchdog, a 64 bit frame takes about 2.6 us
	initial
	begin
		#(NUM_FRAMES * 3000);
		$display("Watchdog expired before all frames completed");
		$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire
